/* files.f */
game_pkg.sv
enemy_cfg.sv
enemy_ctl.sv
hit_detect.sv
enemy_missile_ctl.sv
sprite_draw.sv
enemy_layer.sv
tb_enemy_layer.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the enemy layer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_enemy_layer -f files.f \
  -o sim_enemy_layer > build.log 2>&1 &&
  ./obj_dir/sim_enemy_layer > sim.log 2>&1 ||
  { echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb_enemy_layer.sv */
// testbench for the enemy layer
// drives an abbreviated raster, checks outputs against a reference model by assertions

`timescale 1ns/1ps

module tb_enemy_layer import game_pkg::*; ();

  localparam int X_MAX  = int'(SCREEN_W) - int'(ENEMY_W);
  localparam int E_W    = int'(ENEMY_W);
  localparam int E_H    = int'(ENEMY_H);
  localparam int E_Y    = int'(ENEMY_Y);
  localparam int M_W    = int'(MISSILE_W);
  localparam int M_H    = int'(MISSILE_H);
  localparam int M_STEP = int'(MISSILE_STEP);
  localparam int SCR_H  = int'(SCREEN_H);

  logic pclk, rst_n_i, cfg_we_i, alive_o;
  logic [1:0] cfg_addr_i;
  logic [3:0] cfg_wdata_i;
  vga_bus_t vga_in_i, vga_out_o;
  obj_t player_missile_i, enemy_missile_o;
  pos_t enemy_pos_o;
  int mismatches = 0;
  int other_errors = 0;

  // reference model state
  logic [3:0] m_step;
  logic m_fire, m_respawn, m_tick, m_dir_left, m_alive, m_mis_on;
  int m_x, m_mis_x, m_mis_y;
  vga_bus_t m_p1, m_p2;  // two pixels in flight

  enemy_layer uut (.*);

  initial begin
    pclk = 1'b0;
    forever #5 pclk = ~pclk;
  end

  function automatic logic box_covers(vga_bus_t px, int bx, int by, int w, int h, logic on);
    return on && !px.hblnk && !px.vblnk && int'(px.hcount) >= bx && int'(px.hcount) < bx + w
           && int'(px.vcount) >= by && int'(px.vcount) < by + h;
  endfunction

  function automatic logic boxes_overlap(int ax, int ay, int aw, int ah,
                                         int bx, int by, int bw, int bh);
    return ax < bx + bw && bx < ax + aw && ay < by + bh && by < ay + ah;
  endfunction

  always @(posedge pclk or negedge rst_n_i) begin : ref_model
    vga_bus_t stage;
    int nx;
    if (!rst_n_i) begin
      m_step     <= STEP_RESET;
      m_fire     <= 1'b0;
      m_respawn  <= 1'b0;
      m_tick     <= 1'b0;
      m_dir_left <= 1'b0;
      m_x        <= int'(ENEMY_X0);
      m_alive    <= 1'b1;
      m_mis_on   <= 1'b0;
      m_mis_x    <= 0;
      m_mis_y    <= 0;
      m_p1       <= '0;
      m_p2       <= '0;
    end else begin
      m_respawn <= cfg_we_i && cfg_addr_i == CFG_ADDR_RESPAWN;
      if (cfg_we_i && cfg_addr_i == CFG_ADDR_STEP && cfg_wdata_i != 4'd0)
        m_step <= cfg_wdata_i;  // zero step ignored
      if (cfg_we_i && cfg_addr_i == CFG_ADDR_FIRE)
        m_fire <= cfg_wdata_i[0];
      m_tick <= vga_in_i.hcount == 11'd0 && vga_in_i.vcount == 11'd0;
      if (m_tick) begin
        nx = m_dir_left ? m_x - int'(m_step) : m_x + int'(m_step);
        if (nx > X_MAX) begin
          m_x        <= X_MAX;
          m_dir_left <= 1'b1;
        end else if (nx < 0) begin
          m_x        <= 0;
          m_dir_left <= 1'b0;
        end else begin
          m_x <= nx;
        end
        if (m_mis_on) begin
          if (m_mis_y + M_STEP >= SCR_H)
            m_mis_on <= 1'b0;
          else
            m_mis_y <= m_mis_y + M_STEP;
        end else if (m_alive && m_fire) begin
          m_mis_on <= 1'b1;
          m_mis_x  <= m_x + E_W / 2;
          m_mis_y  <= E_Y + E_H;
        end
      end
      if (player_missile_i.on && boxes_overlap(int'(player_missile_i.pos.x),
          int'(player_missile_i.pos.y), M_W, M_H, m_x, E_Y, E_W, E_H))
        m_alive <= 1'b0;
      else if (m_respawn)
        m_alive <= 1'b1;
      stage = vga_in_i;
      if (box_covers(stage, m_x, E_Y, E_W, E_H, m_alive))
        stage.rgb = ENEMY_RGB;
      m_p1 <= stage;
      stage = m_p1;
      if (box_covers(stage, m_mis_x, m_mis_y, M_W, M_H, m_mis_on))
        stage.rgb = MISSILE_RGB;  // missile on top
      m_p2 <= stage;
    end
  end

  a_timing: assert property (@(posedge pclk) disable iff (!rst_n_i)
    vga_out_o[37:12] == m_p2[37:12]) else begin
    mismatches++;
    $display("mismatch vga_out_o timing: got %h expected %h", vga_out_o[37:12], m_p2[37:12]);
  end

  a_rgb: assert property (@(posedge pclk) disable iff (!rst_n_i)
    vga_out_o.rgb == m_p2.rgb) else begin
    mismatches++;
    $display("mismatch vga_out_o.rgb: got %h expected %h", vga_out_o.rgb, m_p2.rgb);
  end

  a_pos: assert property (@(posedge pclk) disable iff (!rst_n_i)
    int'(enemy_pos_o.x) == m_x && int'(enemy_pos_o.y) == E_Y) else begin
    mismatches++;
    $display("mismatch enemy_pos_o: got %h expected %h", enemy_pos_o, {m_x[10:0], ENEMY_Y});
  end

  a_alive: assert property (@(posedge pclk) disable iff (!rst_n_i)
    alive_o == m_alive) else begin
    mismatches++;
    $display("mismatch alive_o: got %h expected %h", alive_o, m_alive);
  end

  a_missile: assert property (@(posedge pclk) disable iff (!rst_n_i)
    enemy_missile_o.on == m_mis_on && (!m_mis_on ||
    (int'(enemy_missile_o.pos.x) == m_mis_x && int'(enemy_missile_o.pos.y) == m_mis_y)))
  else begin
    mismatches++;
    $display("mismatch enemy_missile_o: got %h expected %h", enemy_missile_o,
             {m_mis_on, m_mis_x[10:0], m_mis_y[10:0]});
  end

  task automatic next_cycle();
    @(posedge pclk);
    #1;
    cfg_we_i = 1'b0;
  endtask

  task automatic set_pixel(int h, int v, logic hb, logic vb);
    logic [31:0] r;
    r = $urandom;
    vga_in_i.hcount = h[10:0];
    vga_in_i.vcount = v[10:0];
    vga_in_i.hsync  = r[12];
    vga_in_i.vsync  = r[13];
    vga_in_i.hblnk  = hb;
    vga_in_i.vblnk  = vb;
    vga_in_i.rgb    = r[11:0];
  endtask

  task automatic set_random_pixel();
    logic [31:0] r;
    r = $urandom;
    // vcount never 0, so no stray frame start
    set_pixel(int'(r % 1056), 1 + int'(r[31:16] % 627), r[2:0] == 3'd0, r[5:3] == 3'd0);
  endtask

  task automatic write_cfg(logic [1:0] addr, logic [3:0] data);
    next_cycle();
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    set_random_pixel();
  endtask

  // corners, edges and centre of a box, a few of them blanked
  task automatic probe_box(int x, int y, int w, int h);
    int offs_x[4];
    int offs_y[4];
    logic [31:0] r;
    offs_x = '{-1, 0, w - 1, w};
    offs_y = '{-1, 0, h - 1, h};
    foreach (offs_y[j]) begin
      foreach (offs_x[i]) begin
        r = $urandom;
        next_cycle();
        set_pixel(x + offs_x[i], y + offs_y[j], r[2:0] == 3'd0, r[5:3] == 3'd0);
      end
    end
    next_cycle();
    set_pixel(x + w / 2, y + h / 2, 1'b0, 1'b0);
  endtask

  task automatic run_frame();
    next_cycle();
    set_pixel(0, 0, 1'b0, 1'b0);
    repeat (2) begin  // enemy step lands before the probes
      next_cycle();
      set_random_pixel();
    end
    probe_box(m_x, E_Y, E_W, E_H);
    probe_box(m_mis_x, m_mis_y, M_W, M_H);
    repeat (4) begin
      next_cycle();
      set_random_pixel();
    end
  endtask

  task automatic frames_until_x(int target, int max_frames);
    int n;
    n = 0;
    while (int'(enemy_pos_o.x) != target && n < max_frames) begin
      run_frame();
      n++;
    end
    if (int'(enemy_pos_o.x) != target) begin
      other_errors++;
      $display("enemy never reached column %0d", target);
    end
  endtask

  task automatic frames_until_missile(logic want, int max_frames);
    int n;
    n = 0;
    while (enemy_missile_o.on != want && n < max_frames) begin
      run_frame();
      n++;
    end
    if (enemy_missile_o.on != want) begin
      other_errors++;
      $display("enemy missile did not turn %s in time", want ? "on" : "off");
    end
  endtask

  task automatic cycles_until_alive(logic want, int max_cycles);
    int n;
    n = 0;
    while (alive_o != want && n < max_cycles) begin
      next_cycle();
      set_random_pixel();
      n++;
    end
    if (alive_o != want) begin
      other_errors++;
      $display("alive flag did not change in time");
    end
  endtask

  initial begin
    void'($urandom(32'h9dea));
    rst_n_i          = 1'b0;
    vga_in_i         = '0;
    player_missile_i = '0;
    cfg_we_i         = 1'b0;
    cfg_addr_i       = 2'd0;
    cfg_wdata_i      = 4'd0;
    repeat (8) @(posedge pclk);
    #1;
    a_reset_out: assert (vga_out_o == '0) else begin
      mismatches++;
      $display("mismatch vga_out_o in reset: got %h expected %h", vga_out_o, 38'h0);
    end
    rst_n_i = 1'b1;
    repeat (3) run_frame();  // default step, fire disabled
    write_cfg(CFG_ADDR_STEP, 4'd0);
    write_cfg(CFG_ADDR_STEP, 4'd15);
    frames_until_x(X_MAX, 60);
    frames_until_x(0, 70);
    write_cfg(CFG_ADDR_STEP, 4'd3);
    repeat (4) run_frame();
    write_cfg(CFG_ADDR_FIRE, 4'd1);
    frames_until_missile(1'b1, 3);
    frames_until_missile(1'b0, 80);
    player_missile_i.on    = 1'b1;
    player_missile_i.pos.x = 11'(m_x + 8);
    player_missile_i.pos.y = 11'(E_Y + 4);
    cycles_until_alive(1'b0, 8);
    player_missile_i = '0;
    repeat (3) run_frame();  // dead enemy, no paint and no launch
    write_cfg(CFG_ADDR_RESPAWN, 4'd0);
    cycles_until_alive(1'b1, 8);
    repeat (3) run_frame();
    $display("errors: %0d mismatch, %0d other", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

/* enemy_layer.sv */
// enemy layer of the shooter game
// moves and kills the enemy, fires its missile and overlays both on the raster

`timescale 1ns/1ps

module enemy_layer import game_pkg::*; (
  input  logic       pclk,
  input  logic       rst_n_i,
  input  vga_bus_t   vga_in_i,
  input  obj_t       player_missile_i,
  input  logic       cfg_we_i,
  input  logic [1:0] cfg_addr_i,
  input  logic [3:0] cfg_wdata_i,
  output vga_bus_t   vga_out_o,
  output logic       alive_o,
  output pos_t       enemy_pos_o,
  output obj_t       enemy_missile_o
);

  enemy_cfg_t cfg;
  logic       frame_tick;
  pos_t       enemy_pos;
  logic       alive;
  obj_t       enemy_missile;
  vga_bus_t   vga_enemy;  // between the two overlay stages

  enemy_cfg u_cfg (
    .pclk    (pclk),
    .rst_n_i (rst_n_i),
    .we_i    (cfg_we_i),
    .addr_i  (cfg_addr_i),
    .wdata_i (cfg_wdata_i),
    .cfg_o   (cfg)
  );

  enemy_ctl u_ctl (
    .pclk         (pclk),
    .rst_n_i      (rst_n_i),
    .vga_i        (vga_in_i),
    .cfg_i        (cfg),
    .frame_tick_o (frame_tick),
    .pos_o        (enemy_pos)
  );

  hit_detect u_hit (
    .pclk      (pclk),
    .rst_n_i   (rst_n_i),
    .missile_i (player_missile_i),
    .enemy_i   (enemy_pos),
    .cfg_i     (cfg),
    .alive_o   (alive)
  );

  enemy_missile_ctl u_missile_ctl (
    .pclk         (pclk),
    .rst_n_i      (rst_n_i),
    .frame_tick_i (frame_tick),
    .cfg_i        (cfg),
    .enemy_i      (enemy_pos),
    .alive_i      (alive),
    .missile_o    (enemy_missile)
  );

  sprite_draw #(.W(ENEMY_W), .H(ENEMY_H), .RGB(ENEMY_RGB)) u_draw_enemy (
    .pclk    (pclk),
    .rst_n_i (rst_n_i),
    .vga_i   (vga_in_i),
    .pos_i   (enemy_pos),
    .on_i    (alive),
    .vga_o   (vga_enemy)
  );

  // missile last so it paints over the enemy
  sprite_draw #(.W(MISSILE_W), .H(MISSILE_H), .RGB(MISSILE_RGB)) u_draw_missile (
    .pclk    (pclk),
    .rst_n_i (rst_n_i),
    .vga_i   (vga_enemy),
    .pos_i   (enemy_missile.pos),
    .on_i    (enemy_missile.on),
    .vga_o   (vga_out_o)
  );

  assign alive_o         = alive;
  assign enemy_pos_o     = enemy_pos;
  assign enemy_missile_o = enemy_missile;

endmodule

/* sprite_draw.sv */
// solid box overlay stage
// delays the raster one cycle and paints RGB where the box covers a visible pixel

`timescale 1ns/1ps

module sprite_draw import game_pkg::*; #(
  parameter logic [10:0] W   = 11'd8,
  parameter logic [10:0] H   = 11'd8,
  parameter logic [11:0] RGB = 12'hfff
) (
  input  logic     pclk,
  input  logic     rst_n_i,
  input  vga_bus_t vga_i,
  input  pos_t     pos_i,
  input  logic     on_i,
  output vga_bus_t vga_o
);

  logic [11:0] x_end, y_end;
  logic        in_x, in_y;
  logic        visible;
  logic        paint;

  assign x_end = {1'b0, pos_i.x} + {1'b0, W};
  assign y_end = {1'b0, pos_i.y} + {1'b0, H};

  assign in_x = (vga_i.hcount >= pos_i.x) && ({1'b0, vga_i.hcount} < x_end);
  assign in_y = (vga_i.vcount >= pos_i.y) && ({1'b0, vga_i.vcount} < y_end);

  assign visible = !vga_i.hblnk && !vga_i.vblnk;
  assign paint   = on_i && visible && in_x && in_y;

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vga_o <= '0;
    end else begin
      vga_o <= vga_i;  // timing fields pass unchanged
      if (paint)
        vga_o.rgb <= RGB;
    end
  end

endmodule

/* enemy_missile_ctl.sv */
// enemy missile control
// launches one missile from the enemy, drops it each frame, retires it at the bottom

`timescale 1ns/1ps

module enemy_missile_ctl import game_pkg::*; (
  input  logic       pclk,
  input  logic       rst_n_i,
  input  logic       frame_tick_i,
  input  enemy_cfg_t cfg_i,
  input  pos_t       enemy_i,
  input  logic       alive_i,
  output obj_t       missile_o
);

  logic        on_q;
  logic [10:0] x_q;
  logic [10:0] y_q;
  logic [11:0] y_next;

  assign y_next = {1'b0, y_q} + {1'b0, MISSILE_STEP};

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      on_q <= 1'b0;
      x_q  <= 11'd0;
      y_q  <= 11'd0;
    end else if (frame_tick_i) begin
      if (on_q) begin
        if (y_next >= {1'b0, SCREEN_H})
          on_q <= 1'b0;  // off the bottom
        else
          y_q <= y_next[10:0];
      end else if (alive_i && cfg_i.fire_en) begin
        on_q <= 1'b1;
        x_q  <= enemy_i.x + (ENEMY_W >> 1);  // centre bottom of enemy
        y_q  <= enemy_i.y + ENEMY_H;
      end
    end
  end

  assign missile_o.on    = on_q;
  assign missile_o.pos.x = x_q;
  assign missile_o.pos.y = y_q;

  // checked across launch and descent, y must stay on screen while visible
  a_missile_on_screen: assert property (
    @(posedge pclk) disable iff (!rst_n_i) missile_o.on |-> missile_o.pos.y < SCREEN_H
  ) else $error("enemy_missile_ctl: missile y %h past bottom", missile_o.pos.y);

endmodule

/* hit_detect.sv */
// enemy hit detection
// overlaps the player missile box with the enemy box and keeps the alive flag

`timescale 1ns/1ps

module hit_detect import game_pkg::*; (
  input  logic       pclk,
  input  logic       rst_n_i,
  input  obj_t       missile_i,
  input  pos_t       enemy_i,
  input  enemy_cfg_t cfg_i,
  output logic       alive_o
);

  logic [11:0] m_x_end, m_y_end;
  logic [11:0] e_x_end, e_y_end;
  logic        overlap_x, overlap_y;
  logic        hit;

  assign m_x_end = {1'b0, missile_i.pos.x} + {1'b0, MISSILE_W};
  assign m_y_end = {1'b0, missile_i.pos.y} + {1'b0, MISSILE_H};
  assign e_x_end = {1'b0, enemy_i.x} + {1'b0, ENEMY_W};
  assign e_y_end = {1'b0, enemy_i.y} + {1'b0, ENEMY_H};

  // half-open boxes, touching edges do not count
  assign overlap_x = ({1'b0, missile_i.pos.x} < e_x_end) &&
                     ({1'b0, enemy_i.x} < m_x_end);
  assign overlap_y = ({1'b0, missile_i.pos.y} < e_y_end) &&
                     ({1'b0, enemy_i.y} < m_y_end);

  assign hit = missile_i.on && overlap_x && overlap_y;

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      alive_o <= 1'b1;
    end else if (hit) begin
      alive_o <= 1'b0;  // hit wins over a same-cycle respawn
    end else if (cfg_i.respawn) begin
      alive_o <= 1'b1;
    end
  end

endmodule

/* enemy_ctl.sv */
// enemy motion control
// detects frame start on the raster and bounces the enemy sideways each frame

`timescale 1ns/1ps

module enemy_ctl import game_pkg::*; (
  input  logic       pclk,
  input  logic       rst_n_i,
  input  vga_bus_t   vga_i,
  input  enemy_cfg_t cfg_i,
  output logic       frame_tick_o,
  output pos_t       pos_o
);

  logic        frame_start;
  logic [10:0] x_q;
  logic        dir_left_q;  // 0 moves right
  logic [11:0] x_right;
  logic [11:0] x_max;

  assign frame_start = (vga_i.hcount == 11'd0) && (vga_i.vcount == 11'd0);

  // one bit wider so the sum cannot wrap
  assign x_right = {1'b0, x_q} + {8'd0, cfg_i.step};
  assign x_max   = {1'b0, SCREEN_W - ENEMY_W};

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      frame_tick_o <= 1'b0;
      x_q          <= ENEMY_X0;
      dir_left_q   <= 1'b0;
    end else begin
      frame_tick_o <= frame_start;
      if (frame_tick_o) begin
        if (!dir_left_q) begin
          if (x_right > x_max) begin  // clamp at right edge and turn
            x_q        <= x_max[10:0];
            dir_left_q <= 1'b1;
          end else begin
            x_q <= x_right[10:0];
          end
        end else begin
          if (x_q < {7'd0, cfg_i.step}) begin
            x_q        <= 11'd0;
            dir_left_q <= 1'b0;
          end else begin
            x_q <= x_q - {7'd0, cfg_i.step};
          end
        end
      end
    end
  end

  assign pos_o.x = x_q;
  assign pos_o.y = ENEMY_Y;

  a_x_in_bounds: assert property (
    @(posedge pclk) disable iff (!rst_n_i) {1'b0, pos_o.x} <= x_max
  ) else $error("enemy_ctl: x out of bounds %h", pos_o.x);

endmodule

/* enemy_cfg.sv */
// enemy configuration registers
// holds movement step and fire enable, turns a respawn write into a pulse

`timescale 1ns/1ps

module enemy_cfg import game_pkg::*; (
  input  logic       pclk,
  input  logic       rst_n_i,
  input  logic       we_i,
  input  logic [1:0] addr_i,
  input  logic [3:0] wdata_i,
  output enemy_cfg_t cfg_o
);

  logic [3:0] step_q;
  logic       fire_q;
  logic       respawn_q;

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      step_q    <= STEP_RESET;
      fire_q    <= 1'b0;
      respawn_q <= 1'b0;
    end else begin
      respawn_q <= 1'b0;  // strobe, not a stored bit
      if (we_i) begin
        case (addr_i)
          CFG_ADDR_STEP: begin
            if (wdata_i != 4'd0)  // zero step would freeze the enemy
              step_q <= wdata_i;
          end
          CFG_ADDR_FIRE:    fire_q    <= wdata_i[0];
          CFG_ADDR_RESPAWN: respawn_q <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  assign cfg_o.step    = step_q;
  assign cfg_o.fire_en = fire_q;
  assign cfg_o.respawn = respawn_q;

  // a stuck enemy would break the bounce behaviour downstream
  a_step_nonzero: assert property (
    @(posedge pclk) disable iff (!rst_n_i) cfg_o.step != 4'd0
  ) else $error("enemy_cfg: step is zero");

endmodule

/* game_pkg.sv */
// game package for the enemy layer
// raster, position and configuration types plus screen and sprite constants

package game_pkg;

  // one raster pixel as it travels down the overlay chain
  typedef struct packed {
    logic [10:0] hcount;
    logic [10:0] vcount;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
    logic [11:0] rgb;
  } vga_bus_t;

  typedef struct packed {
    logic [10:0] x;
    logic [10:0] y;
  } pos_t;

  // missile style object, position plus visibility
  typedef struct packed {
    logic on;
    pos_t pos;
  } obj_t;

  typedef struct packed {
    logic [3:0] step;     // pixels per frame
    logic       fire_en;
    logic       respawn;  // one-cycle pulse
  } enemy_cfg_t;

  localparam logic [10:0] SCREEN_W = 11'd800;
  localparam logic [10:0] SCREEN_H = 11'd600;

  localparam logic [10:0] ENEMY_W   = 11'd32;
  localparam logic [10:0] ENEMY_H   = 11'd24;
  localparam logic [10:0] MISSILE_W = 11'd4;
  localparam logic [10:0] MISSILE_H = 11'd12;

  localparam logic [10:0] ENEMY_Y      = 11'd64;   // enemy row never changes
  localparam logic [10:0] ENEMY_X0     = 11'd100;
  localparam logic [10:0] MISSILE_STEP = 11'd8;

  localparam logic [11:0] ENEMY_RGB   = 12'hf00;
  localparam logic [11:0] MISSILE_RGB = 12'hff0;

  localparam logic [1:0] CFG_ADDR_STEP    = 2'd0;
  localparam logic [1:0] CFG_ADDR_FIRE    = 2'd1;
  localparam logic [1:0] CFG_ADDR_RESPAWN = 2'd2;

  localparam logic [3:0] STEP_RESET = 4'd2;

endpackage
